/* issueFront.f */
hdl/hazardPkg.sv
hdl/instrDecode.sv
hdl/shadowPipe.sv
hdl/hazDet.sv
hdl/pcUnit.sv
hdl/issueFront.sv
testbench/clockGen.sv
testbench/issueFront_props.sv
testbench/issueFrontTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := issueFrontTb
FILELIST  := issueFront.f
BUILDDIR  := obj_dir
VFLAGS    := --binary --timing --assert --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
LINTFLAGS := --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)
SIMARGS   := +verilator+error+limit+100
PASSMSG   := Simulation completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS)

run: build
	@out="$$(./$(BUILDDIR)/V$(TOP) $(SIMARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

lint:
	$(VERILATOR) $(LINTFLAGS)

clean:
	rm -rf $(BUILDDIR)

/* testbench/issueFrontTb.sv */
`timescale 1ns/1ns

module issueFrontTb import hazardPkg::*; ();

    localparam int shadowDepth = 4;
    localparam int resetCycles = 10;
    localparam int driveDelay = 10;
    localparam int stallLimit = shadowDepth + 2;
    localparam int randomCount = 400;
    localparam logic [instrWidth-1:0] idleData = 16'hF000;
    localparam logic [instrWidth-1:0] nopWord = {opNop, 11'd0};

    logic                  clk;
    logic                  reset;
    logic [instrWidth-1:0] instr;
    logic [instrWidth-1:0] reg1Data;
    logic [instrWidth-1:0] pc;
    logic                  nop;
    logic                  pcStall;

    int          stalls;
    int          randIndex;
    logic        issuedNop;
    logic [31:0] randWord;
    logic [31:0] randData;

    clockGen #(.periodNs(100)) clockGen_i (.clk(clk));

    issueFront #(
        .shadowDepth(shadowDepth)
    ) issueFront_i (
        .clk(clk),
        .reset(reset),
        .instr(instr),
        .reg1Data(reg1Data),
        .pc(pc),
        .nop(nop),
        .pcStall(pcStall)
    );

    function automatic logic [15:0] encodeRType(input logic [2:0] srcA, input logic [2:0] srcB,
                                                input logic [2:0] dest);
        return {5'b11000, srcA, srcB, dest, 2'b00};
    endfunction

    function automatic logic [15:0] encodeIType(input logic [4:0] opcode, input logic [2:0] srcA,
                                                input logic [2:0] srcB, input logic [4:0] immVal);
        return {opcode, srcA, srcB, immVal};
    endfunction

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic expectFlag(input string name, input logic got, input logic want);
        assert (got === want)
            else abortRun($sformatf("** Error %s=%h expected %h", name, got, want));
    endtask

    // Present one word, hold it through any stall, return after it issues
    task automatic issue(input logic [instrWidth-1:0] word, input logic [instrWidth-1:0] data);
        instr = word;
        reg1Data = data;
        stalls = 0;
        @(negedge clk);
        while (pcStall) begin
            stalls++;
            if (stalls > stallLimit) begin
                abortRun($sformatf("pcStall stayed high for more than %0d cycles", stallLimit));
            end
            @(negedge clk);
        end
        issuedNop = nop;
        @(posedge clk);
        #driveDelay;
    endtask

    task automatic runIdle(input int count);
        repeat (count) begin
            issue(nopWord, idleData);
        end
    endtask

    // Assertion failures from the bound checker end the run here
    always @(negedge clk) begin
        if (issueFront_i.issueFrontProps_i.failCount != 0) begin
            abortRun("an assertion in issueFrontProps failed");
        end
    end

    initial begin
        void'($urandom(53));
        reset = 1'b1;
        instr = nopWord;
        reg1Data = idleData;
        repeat (resetCycles) @(posedge clk);
        #driveDelay;
        reset = 1'b0;

        runIdle(8);

        // Writer of r3 followed by a reader of r3
        issue(encodeIType(5'b01000, 3'd1, 3'd3, 5'd1), idleData);
        expectFlag("nop", issuedNop, 1'b0);
        issue(encodeRType(3'd3, 3'd2, 3'd4), idleData);
        expectFlag("pcStall", stalls > 0, 1'b1);
        runIdle(shadowDepth);

        // Same address back to back, then two distinct addresses
        issue(encodeIType(opStore, 3'd1, 3'd2, 5'd4), 16'h0040);
        issue(encodeIType(opStore, 3'd1, 3'd2, 5'd4), 16'h0040);
        expectFlag("pcStall", stalls > 0, 1'b1);
        runIdle(shadowDepth);
        issue(encodeIType(opStore, 3'd5, 3'd6, 5'd4), 16'h0040);
        issue(encodeIType(opStore, 3'd5, 3'd6, 5'd4), 16'h0080);
        expectFlag("pcStall", stalls > 0, 1'b0);
        runIdle(shadowDepth);

        // Slot after a jump and after a branch
        issue(encodeIType({ctrlFlowJump, 2'b00}, 3'd0, 3'd0, 5'd3), idleData);
        issue(encodeIType(5'b01000, 3'd5, 3'd6, 5'd0), idleData);
        expectFlag("nop", issuedNop, 1'b1);
        expectFlag("pcStall", stalls > 0, 1'b0);
        runIdle(shadowDepth);
        issue(encodeIType({ctrlFlowBranch, 2'b10}, 3'd0, 3'd0, 5'd7), idleData);
        issue(encodeIType(5'b01000, 3'd5, 3'd6, 5'd0), idleData);
        expectFlag("nop", issuedNop, 1'b1);
        runIdle(shadowDepth);

        // Small reg1Data range so addresses collide often
        for (randIndex = 0; randIndex < randomCount; randIndex++) begin
            randWord = $urandom;
            randData = $urandom;
            issue(randWord[15:0], {13'd0, randData[2:0]});
        end
        runIdle(shadowDepth);
        @(negedge clk);

        if (issueFront_i.issueFrontProps_i.failCount != 0) begin
            abortRun("an assertion in issueFrontProps failed");
        end else begin
            $display("Simulation completed successfully");
            $finish;
        end
    end

endmodule

/* testbench/issueFront_props.sv */
`timescale 1ns/1ns

module issueFrontProps import hazardPkg::*; #(
    parameter int shadowDepth = 4
) (
    input logic                  clk,
    input logic                  reset,
    input logic [instrWidth-1:0] instr,
    input logic [instrWidth-1:0] reg1Data,
    input logic [instrWidth-1:0] pc,
    input logic                  nop,
    input logic                  pcStall
);

    int failCount = 0;

    logic [4:0]             opcode;
    logic                   nopOp;
    logic                   memOp;
    logic                   ctrlOp;
    logic                   writesOp;
    logic [regIdxWidth-1:0] dest;
    logic [instrWidth-1:0]  addr;

    logic                   lastStall;
    logic [instrWidth-1:0]  lastPc;
    logic [instrWidth-1:0]  pcExpect;
    logic                   nopExpect;
    logic                   lastWrite;
    logic [regIdxWidth-1:0] lastDest;
    logic                   lastMem;
    logic [instrWidth-1:0]  lastAddr;
    logic                   lastCtrl;
    int                     stallRun;

    // Own decode of the presented instruction
    assign opcode = instr[15:11];
    assign nopOp = (opcode == opNop);
    assign memOp = (opcode == opLoad) || (opcode == opStore);
    assign ctrlOp = (instr[15:13] == ctrlFlowJump) || (instr[15:13] == ctrlFlowBranch);
    assign writesOp = (opcode[4:3] == 2'b11) || (opcode[4:2] == 3'b010) || (opcode == opLoad);
    assign dest = (opcode[4:3] == 2'b11) ? instr[4:2] : instr[7:5];
    assign addr = reg1Data + {{11{instr[4]}}, instr[4:0]};

    // What the previous cycle issued
    always_ff @(posedge clk) begin
        if (reset) begin
            lastStall <= 1'b1;
            lastPc <= '0;
            lastWrite <= 1'b0;
            lastMem <= 1'b0;
            lastCtrl <= 1'b0;
            stallRun <= 0;
        end else begin
            lastStall <= pcStall;
            lastPc <= pc;
            lastWrite <= writesOp & ~nop;
            lastDest <= dest;
            lastMem <= memOp & ~nop;
            lastAddr <= addr;
            lastCtrl <= ctrlOp & ~pcStall;
            stallRun <= pcStall ? stallRun + 1 : 0;
        end
    end

    // First cycle after reset expects pc of zero
    assign pcExpect = lastStall ? lastPc : lastPc + 16'd2;

    // Stall or a pending squash raises nop, except on the NOP opcode
    assign nopExpect = !nopOp && (pcStall || lastCtrl);

    pcTrack: assert property (@(posedge clk) disable iff (reset) pc == pcExpect)
        else begin
            failCount = failCount + 1;
            $error("** Error pc=%h expected %h", $sampled(pc), $sampled(pcExpect));
        end

    nopRule: assert property (@(posedge clk) disable iff (reset) nop == nopExpect)
        else begin
            failCount = failCount + 1;
            $error("** Error nop=%h expected %h", $sampled(nop), $sampled(nopExpect));
        end

    nopQuiet: assert property (@(posedge clk) disable iff (reset) nopOp |-> !nop && !pcStall)
        else begin
            failCount = failCount + 1;
            $error("** Error nop=%h pcStall=%h expected 0", $sampled(nop), $sampled(pcStall));
        end

    regRaw: assert property (@(posedge clk) disable iff (reset)
        lastWrite && !nopOp && (instr[10:8] == lastDest || instr[7:5] == lastDest) |-> pcStall)
        else begin
            failCount = failCount + 1;
            $error("** Error pcStall=%h expected 1 on r%h", $sampled(pcStall), $sampled(lastDest));
        end

    memRaw: assert property (@(posedge clk) disable iff (reset)
        lastMem && memOp && addr == lastAddr |-> pcStall)
        else begin
            failCount = failCount + 1;
            $error("** Error pcStall=%h expected 1 at %h", $sampled(pcStall), $sampled(addr));
        end

    squash: assert property (@(posedge clk) disable iff (reset) lastCtrl && !nopOp |-> nop)
        else begin
            failCount = failCount + 1;
            $error("** Error nop=%h expected 1 after jump or branch", $sampled(nop));
        end

    stallBound: assert property (@(posedge clk) disable iff (reset) stallRun <= shadowDepth)
        else begin
            failCount = failCount + 1;
            $error("** Error stallRun=%h exceeds %h", $sampled(stallRun), shadowDepth);
        end

endmodule

bind issueFront issueFrontProps #(
    .shadowDepth(shadowDepth)
) issueFrontProps_i (
    .clk(clk),
    .reset(reset),
    .instr(instr),
    .reg1Data(reg1Data),
    .pc(pc),
    .nop(nop),
    .pcStall(pcStall)
);

/* testbench/clockGen.sv */
`timescale 1ns/1ns

module clockGen #(
    parameter int periodNs = 100
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever begin
            #(periodNs / 2) clk = ~clk;
        end
    end

endmodule

/* hdl/issueFront.sv */
`timescale 1ns/1ns

module issueFront import hazardPkg::*; #(
    parameter int shadowDepth = 4
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [instrWidth-1:0] instr,
    input  logic [instrWidth-1:0] reg1Data,
    output logic [instrWidth-1:0] pc,
    output logic                  nop,
    output logic                  pcStall
);

    logic [regIdxWidth-1:0] rs;
    logic [regIdxWidth-1:0] rt;
    logic [regIdxWidth-1:0] rd;
    logic [instrWidth-1:0]  imm;
    logic                   writesReg;
    logic                   isMem;
    logic                   isCtrlFlow;
    logic                   isNop;

    instrDecode instrDecode_i (
        .instr(instr),
        .rs(rs),
        .rt(rt),
        .rd(rd),
        .imm(imm),
        .writesReg(writesReg),
        .isMem(isMem),
        .isCtrlFlow(isCtrlFlow),
        .isNop(isNop)
    );

    hazDet #(
        .shadowDepth(shadowDepth)
    ) hazDet_i (
        .clk(clk),
        .reset(reset),
        .rs(rs),
        .rt(rt),
        .rd(rd),
        .imm(imm),
        .reg1Data(reg1Data),
        .writesReg(writesReg),
        .isMem(isMem),
        .isCtrlFlow(isCtrlFlow),
        .isNop(isNop),
        .nop(nop),
        .pcStall(pcStall)
    );

    // PC holds whenever hazDet asks for a stall
    pcUnit pcUnit_i (
        .clk(clk),
        .reset(reset),
        .pcStall(pcStall),
        .pc(pc)
    );

endmodule

/* hdl/pcUnit.sv */
`timescale 1ns/1ns

module pcUnit import hazardPkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  pcStall,
    output logic [instrWidth-1:0] pc
);

    // Instructions are one halfword wide
    localparam logic [instrWidth-1:0] pcStep = 16'd2;

    logic [instrWidth-1:0] pcNext;

    always_comb begin
        if (pcStall) begin
            pcNext = pc;
        end else begin
            pcNext = pc + pcStep;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

/* hdl/hazDet.sv */
`timescale 1ns/1ns

module hazDet import hazardPkg::*; #(
    parameter int shadowDepth = 4
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [regIdxWidth-1:0] rs,
    input  logic [regIdxWidth-1:0] rt,
    input  logic [regIdxWidth-1:0] rd,
    input  logic [instrWidth-1:0]  imm,
    input  logic [instrWidth-1:0]  reg1Data,
    input  logic                   writesReg,
    input  logic                   isMem,
    input  logic                   isCtrlFlow,
    input  logic                   isNop,
    output logic                   nop,
    output logic                   pcStall
);

    logic [instrWidth-1:0] memAddr;

    regTagT regEnter;
    regTagT regStages [shadowDepth];
    memTagT memEnter;
    memTagT memStages [shadowDepth];

    logic regMatch;
    logic memEnAny;
    logic memAddrAny;
    logic regHaz;
    logic memHaz;
    logic squashQ;

    // Effective address of the current access
    assign memAddr = reg1Data + imm;

    // Register RAW against every older writer still in flight
    always_comb begin
        regMatch = 1'b0;
        for (int i = 0; i < shadowDepth; i++) begin
            if (regStages[i].valid &&
                ((regStages[i].dest == rs) || (regStages[i].dest == rt))) begin
                regMatch = 1'b1;
            end
        end
    end

    assign regHaz = regMatch & ~isNop;

    // Enable and address are reduced separately, then combined
    always_comb begin
        memEnAny = 1'b0;
        memAddrAny = 1'b0;
        for (int i = 0; i < shadowDepth; i++) begin
            if (memStages[i].enable) begin
                memEnAny = 1'b1;
            end
            if (memStages[i].addr == memAddr) begin
                memAddrAny = 1'b1;
            end
        end
    end

    assign memHaz = isMem & memEnAny & memAddrAny;

    assign pcStall = (regHaz | memHaz) & ~isNop;
    assign nop = (pcStall | squashQ) & ~isNop;

    // Slot after a jump or branch gets squashed
    always_ff @(posedge clk) begin
        if (reset) begin
            squashQ <= 1'b0;
        end else begin
            squashQ <= isCtrlFlow & ~regHaz & ~memHaz;
        end
    end

    // Bubbles enter the history with valid and enable cleared
    always_comb begin
        regEnter = '0;
        memEnter = '0;
        if (!nop) begin
            regEnter.dest = rd;
            regEnter.valid = writesReg;
            memEnter.addr = memAddr;
            memEnter.enable = isMem;
        end
    end

    shadowPipe #(
        .payloadT(regTagT),
        .shadowDepth(shadowDepth)
    ) regShadow (
        .clk(clk),
        .reset(reset),
        .enter(regEnter),
        .stages(regStages)
    );

    shadowPipe #(
        .payloadT(memTagT),
        .shadowDepth(shadowDepth)
    ) memShadow (
        .clk(clk),
        .reset(reset),
        .enter(memEnter),
        .stages(memStages)
    );

endmodule

/* hdl/shadowPipe.sv */
`timescale 1ns/1ns

module shadowPipe #(
    parameter type payloadT = logic [3:0],
    parameter int shadowDepth = 4
) (
    input  logic    clk,
    input  logic    reset,
    input  payloadT enter,
    output payloadT stages [shadowDepth]
);

    // Stage 0 is ID, the last stage is the oldest (WB for depth 4)
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < shadowDepth; i++) begin
                stages[i] <= '0;
            end
        end else begin
            stages[0] <= enter;
            for (int i = 1; i < shadowDepth; i++) begin
                stages[i] <= stages[i-1];
            end
        end
    end

    // A zero payload is always an invalid bubble since the flag bit is clear

endmodule

/* hdl/instrDecode.sv */
`timescale 1ns/1ns

module instrDecode import hazardPkg::*; (
    input  logic [instrWidth-1:0]  instr,
    output logic [regIdxWidth-1:0] rs,
    output logic [regIdxWidth-1:0] rt,
    output logic [regIdxWidth-1:0] rd,
    output logic [instrWidth-1:0]  imm,
    output logic                   writesReg,
    output logic                   isMem,
    output logic                   isCtrlFlow,
    output logic                   isNop
);

    logic [opcodeWidth-1:0]   opcode;
    logic [ctrlFlowWidth-1:0] ctrlClass;
    logic                     isRType;
    logic                     isLoad;
    logic                     isStore;

    assign opcode = instr[instrWidth-1 -: opcodeWidth];
    assign ctrlClass = instr[instrWidth-1 -: ctrlFlowWidth];

    // Register fields sit at fixed positions for every format
    assign rs = instr[10:8];
    assign rt = instr[7:5];

    // R-format opcodes start with 11 and carry rd in the low bits
    assign isRType = (opcode[opcodeWidth-1 -: 2] == 2'b11);

    always_comb begin
        if (isRType) begin
            rd = instr[4:2];
        end else begin
            rd = instr[7:5];
        end
    end

    assign isLoad = (opcode == opLoad);
    assign isStore = (opcode == opStore);

    // R-format, immediate ALU ops (010xx) and loads write back
    always_comb begin
        writesReg = 1'b0;
        if (isRType) begin
            writesReg = 1'b1;
        end else if (opcode[opcodeWidth-1 -: 3] == 3'b010) begin
            writesReg = 1'b1;
        end else if (isLoad) begin
            writesReg = 1'b1;
        end
    end

    assign isMem = isLoad | isStore;

    always_comb begin
        case (ctrlClass)
            ctrlFlowJump:   isCtrlFlow = 1'b1;
            ctrlFlowBranch: isCtrlFlow = 1'b1;
            default:        isCtrlFlow = 1'b0;
        endcase
    end

    assign isNop = (opcode == opNop);

    // Five bit immediate, sign extended to the datapath width
    assign imm = {{(instrWidth - immWidth){instr[immWidth-1]}}, instr[immWidth-1:0]};

endmodule

/* hdl/hazardPkg.sv */
package hazardPkg;

    // Datapath and register file geometry
    parameter int instrWidth = 16;
    parameter int regIdxWidth = 3;

    // Primary opcode lives in the top five bits
    parameter int opcodeWidth = 5;
    parameter int immWidth = 5;

    // Control-flow class uses only the top three opcode bits
    parameter int ctrlFlowWidth = 3;

    parameter logic [opcodeWidth-1:0] opNop = 5'b00001;
    parameter logic [opcodeWidth-1:0] opLoad = 5'b10001;
    parameter logic [opcodeWidth-1:0] opStore = 5'b10000;

    parameter logic [ctrlFlowWidth-1:0] ctrlFlowJump = 3'b001;
    parameter logic [ctrlFlowWidth-1:0] ctrlFlowBranch = 3'b011;

    // Destination of an in-flight instruction
    // valid means that stage will write a register
    typedef struct packed {
        logic [regIdxWidth-1:0] dest;
        logic valid;
    } regTagT;

    // Address touched by an in-flight load or store
    typedef struct packed {
        logic [instrWidth-1:0] addr;
        logic enable;
    } memTagT;

endpackage
